// ==== Makefile ====
# Verilator build and run for the voice testbench

VERILATOR ?= verilator
TOP       ?= sid_voice_tb
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_TEXT ?= TESTS PASSED

SIM = $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)

// ==== bench/sid_voice_asserts.sv ====
`timescale 1ns/10ps

module sid_voice_asserts
  import sid_voice_pkg::*;
(
  input logic       clock,
  input logic       reset,
  input phase_t     phase,
  input logic       test,
  input amplitude_t amplitude,
  input logic       osc_msb_out,
  input sample_t    sawtooth,
  input sample_t    signal_out
);

  // Sawtooth register trails the accumulator MSB by one cycle
  msb_leads_sawtooth: assert property (@(posedge clock) disable iff (reset)
    sawtooth[SAMPLE_W-1] == $past(osc_msb_out))
    else $error("sawtooth MSB does not follow osc_msb_out one cycle later");

  test_clears_phase: assert property (@(posedge clock) disable iff (reset)
    test |=> (phase == '0))
    else $error("phase not cleared one cycle after test");

  // Zero level held long enough to reach the product register
  zero_amplitude_silent: assert property (@(posedge clock) disable iff (reset)
    (amplitude == '0) ##1 (amplitude == '0) |-> (signal_out == '0))
    else $error("signal_out nonzero with amplitude held at zero");

endmodule

bind sid_voice sid_voice_asserts voice_checks (
  .clock       (clock),
  .reset       (reset),
  .phase       (phase),
  .test        (test),
  .amplitude   (amplitude),
  .osc_msb_out (osc_msb_out),
  .sawtooth    (sawtooth),
  .signal_out  (signal_out)
);

// ==== bench/sid_voice_tb.sv ====
`timescale 1ns/10ps

module sid_voice_tb
  import sid_voice_pkg::*;
();

  localparam int CLOCK_PERIOD    = 40;
  localparam int RESET_CYCLES    = 4;
  localparam int MAX_ROWS        = 16;
  localparam int WATCHDOG_MARGIN = 50;

  typedef logic [PRODUCT_W-1:0] product_t;

  logic       clock;
  logic       reset;
  reg8_t      freq_lo;
  reg8_t      freq_hi;
  reg8_t      pw_lo;
  logic [3:0] pw_hi;
  reg8_t      control;
  amplitude_t amplitude;
  logic       osc_msb_in;
  logic       osc_msb_out;
  sample_t    signal_out;
  level_t     osc_out;

  // Stimulus table, msb mode 0 low, 1 high, 2 square wave
  string        row_name [MAX_ROWS];
  reg8_t        row_control [MAX_ROWS];
  freq_t        row_freq [MAX_ROWS];
  logic         row_random [MAX_ROWS];
  pulse_width_t row_pw [MAX_ROWS];
  amplitude_t   row_amp [MAX_ROWS];
  logic [1:0]   row_msb [MAX_ROWS];
  int           row_cycles [MAX_ROWS];
  int           num_rows;
  logic         table_ready;

  // Reference model state
  phase_t   model_phase;
  logic     model_sync_prev;
  logic     model_tap_prev;
  lfsr_t    model_lfsr;
  sample_t  model_noise;
  sample_t  model_triangle;
  sample_t  model_sawtooth;
  sample_t  model_pulse;
  product_t model_product;

  logic [15:0] rng_state;
  int          errors;
  int          checks;
  int          row_errors;

  initial clock = 1'b0;
  always #(CLOCK_PERIOD / 2) clock = ~clock;

  sid_voice UUT (
    .clock       (clock),
    .reset       (reset),
    .freq_lo     (freq_lo),
    .freq_hi     (freq_hi),
    .pw_lo       (pw_lo),
    .pw_hi       (pw_hi),
    .control     (control),
    .amplitude   (amplitude),
    .osc_msb_in  (osc_msb_in),
    .osc_msb_out (osc_msb_out),
    .signal_out  (signal_out),
    .osc_out     (osc_out)
  );

  // 16-bit Fibonacci LFSR, taps 16 15 13 4
  function automatic freq_t random_freq();
    freq_t value;
    logic  feedback;
    value = '0;
    for (int i = 0; i < FREQ_W; i++)
    begin
      feedback  = rng_state[15] ^ rng_state[14] ^ rng_state[12] ^ rng_state[3];
      rng_state = {rng_state[14:0], feedback};
      value     = {value[FREQ_W-2:0], rng_state[0]};
    end
    return value;
  endfunction

  function automatic sample_t noise_taps(lfsr_t r);
    return {r[21], r[19], r[15], r[12], r[10], r[6], r[3], r[1], 4'b0000};
  endfunction

  function automatic sample_t selected_sample(reg8_t ctrl);
    sample_t value;
    case (ctrl[7:4])
      SEL_TRIANGLE: value = model_triangle;
      SEL_SAWTOOTH: value = model_sawtooth;
      SEL_PULSE:    value = model_pulse;
      SEL_NOISE:    value = model_noise;
      default:      value = '0;
    endcase
    return value;
  endfunction

  task automatic model_reset();
    model_phase     = '0;
    model_sync_prev = 1'b0;
    model_tap_prev  = 1'b0;
    model_lfsr      = '1;
    model_noise     = '0;
    model_triangle  = '0;
    model_sawtooth  = '0;
    model_pulse     = '0;
    model_product   = '0;
  endtask

  // One rising edge, using the inputs now on the pins
  task automatic model_step();
    freq_t        frequency;
    pulse_width_t width;
    logic         test;
    logic         sync_edge;
    sample_t      saw_next;
    sample_t      tri_next;
    sample_t      pulse_next;
    lfsr_t        lfsr_next;
    frequency = {freq_hi, freq_lo};
    width     = {pw_hi, pw_lo};
    test      = control[CTRL_TEST];
    saw_next  = model_phase[23:12];
    tri_next  = {model_phase[22:12] ^ {11{model_phase[23]}}, 1'b0};
    // Ring modulation inverts the folded ramp
    if (control[CTRL_RING] && osc_msb_in)
      tri_next = {~tri_next[11:1], 1'b0};
    if (test || saw_next >= width)
      pulse_next = '1;
    else
      pulse_next = '0;
    lfsr_next = model_lfsr;
    if (model_phase[NOISE_TAP_BIT] && !model_tap_prev)
      lfsr_next = {model_lfsr[21:0], (model_lfsr[22] | test) ^ model_lfsr[17]};
    sync_edge = control[CTRL_SYNC] && model_sync_prev && !osc_msb_in;

    model_product   = product_t'(selected_sample(control)) * product_t'(amplitude);
    model_noise     = noise_taps(model_lfsr);
    model_lfsr      = lfsr_next;
    model_tap_prev  = model_phase[NOISE_TAP_BIT];
    model_sync_prev = osc_msb_in;
    model_sawtooth  = saw_next;
    model_triangle  = tri_next;
    model_pulse     = pulse_next;
    if (test || sync_edge)
      model_phase = '0;
    else
      model_phase = model_phase + phase_t'(frequency);
  endtask

  task automatic check_level(level_t actual, level_t expected, string what);
    checks++;
    if (actual !== expected)
    begin
      errors++;
      row_errors++;
      $display("FAIL %0d ns: %s expected %h, got %h", $time, what, expected, actual);
    end
  endtask

  task automatic check_sample(sample_t actual, sample_t expected, string what);
    checks++;
    if (actual !== expected)
    begin
      errors++;
      row_errors++;
      $display("FAIL %0d ns: %s expected %h, got %h", $time, what, expected, actual);
    end
  endtask

  task automatic check_msb(logic actual, logic expected, string what);
    checks++;
    if (actual !== expected)
    begin
      errors++;
      row_errors++;
      $display("FAIL %0d ns: %s expected %b, got %b", $time, what, expected, actual);
    end
  endtask

  task automatic check_outputs();
    sample_t selected;
    level_t  expected_level;
    selected       = selected_sample(control);
    expected_level = selected[SAMPLE_W-1 -: LEVEL_W];
    check_level(osc_out, expected_level, "osc_out");
    check_sample(signal_out, model_product[PRODUCT_W-1 -: SAMPLE_W], "signal_out");
    check_msb(osc_msb_out, model_phase[PHASE_W-1], "osc_msb_out");
  endtask

  task automatic add_row(string name, reg8_t ctrl, freq_t freq, logic rnd,
                         pulse_width_t pw, amplitude_t amp, logic [1:0] msb, int cycles);
    row_name[num_rows]    = name;
    row_control[num_rows] = ctrl;
    row_freq[num_rows]    = freq;
    row_random[num_rows]  = rnd;
    row_pw[num_rows]      = pw;
    row_amp[num_rows]     = amp;
    row_msb[num_rows]     = msb;
    row_cycles[num_rows]  = cycles;
    num_rows++;
  endtask

  task automatic build_table();
    num_rows = 0;
    add_row("test sawtooth",  8'h28, 16'h1234, 1'b0, 12'h000, 8'h80, 2'd0, 20);
    add_row("test pulse",     8'h48, 16'h1234, 1'b0, 12'hFFF, 8'h80, 2'd0, 20);
    add_row("noise",          8'h80, 16'hFFFF, 1'b0, 12'h000, 8'hFF, 2'd0, 300);
    add_row("sawtooth rnd a", 8'h20, 16'h0000, 1'b1, 12'h000, 8'hFF, 2'd0, 200);
    add_row("sawtooth rnd b", 8'h20, 16'h0000, 1'b1, 12'h000, 8'h80, 2'd0, 200);
    add_row("pulse",          8'h40, 16'hFFFF, 1'b0, 12'h800, 8'hFF, 2'd0, 300);
    add_row("triangle",       8'h10, 16'hFFFF, 1'b0, 12'h000, 8'hFF, 2'd0, 200);
    add_row("triangle ring",  8'h14, 16'hFFFF, 1'b0, 12'h000, 8'hFF, 2'd1, 200);
    add_row("sync on",        8'h22, 16'hFFFF, 1'b0, 12'h000, 8'hFF, 2'd2, 120);
    add_row("sync off",       8'h20, 16'hFFFF, 1'b0, 12'h000, 8'hFF, 2'd2, 120);
    add_row("amplitude 0",    8'h20, 16'hFFFF, 1'b0, 12'h000, 8'h00, 2'd0, 100);
    add_row("amplitude 128",  8'h20, 16'hFFFF, 1'b0, 12'h000, 8'h80, 2'd0, 100);
    add_row("amplitude 255",  8'h20, 16'hFFFF, 1'b0, 12'h000, 8'hFF, 2'd0, 100);
    add_row("mix saw tri",    8'h30, 16'hFFFF, 1'b0, 12'h000, 8'hFF, 2'd0, 60);
    add_row("mix all",        8'hF0, 16'hFFFF, 1'b0, 12'h400, 8'hFF, 2'd1, 60);
  endtask

  // Cycle 0 of every row runs with the test bit forced on
  task automatic run_row(int r);
    freq_t frequency;
    reg8_t test_mask;
    test_mask            = '0;
    test_mask[CTRL_TEST] = 1'b1;
    frequency            = row_random[r] ? random_freq() : row_freq[r];
    row_errors           = 0;
    for (int c = 0; c <= row_cycles[r]; c++)
    begin
      control    = (c == 0) ? (row_control[r] | test_mask) : row_control[r];
      freq_hi    = frequency[15:8];
      freq_lo    = frequency[7:0];
      pw_hi      = row_pw[r][11:8];
      pw_lo      = row_pw[r][7:0];
      amplitude  = row_amp[r];
      osc_msb_in = (row_msb[r] == 2'd1) || (row_msb[r] == 2'd2 && (c / 8) % 2 == 0);
      model_step();
      @(negedge clock);
      check_outputs();
    end
    if (row_errors == 0)
      $display("Row %0d %s (freq %h): ok", r, row_name[r], frequency);
    else
      $display("Row %0d %s (freq %h): %0d mismatches", r, row_name[r], frequency, row_errors);
  endtask

  initial
  begin
    errors      = 0;
    checks      = 0;
    row_errors  = 0;
    rng_state   = 16'd5;
    table_ready = 1'b0;
    reset       = 1'b1;
    freq_lo     = '0;
    freq_hi     = '0;
    pw_lo       = '0;
    pw_hi       = '0;
    control     = '0;
    amplitude   = '0;
    osc_msb_in  = 1'b0;
    build_table();
    table_ready = 1'b1;
    repeat (RESET_CYCLES) @(negedge clock);
    model_reset();
    check_outputs();
    reset = 1'b0;
    for (int r = 0; r < num_rows; r++)
      run_row(r);
    $display("%0d rows, %0d checks, %0d errors", num_rows, checks, errors);
    if (errors == 0)
      $display("TESTS PASSED");
    else
      $display("TESTS FAILED");
    $finish;
  end

  initial
  begin
    int limit;
    wait (table_ready);
    limit = RESET_CYCLES + WATCHDOG_MARGIN;
    for (int i = 0; i < num_rows; i++)
      limit += row_cycles[i] + 1;
    #(limit * CLOCK_PERIOD);
    $display("Timeout: the tests did not finish within %0d clock cycles", limit);
    $display("TESTS FAILED");
    $finish;
  end

endmodule

// ==== compile.f ====
verilog/sid_voice_pkg.sv
verilog/phase_accumulator.sv
verilog/noise_lfsr.sv
verilog/waveform_generator.sv
verilog/output_stage.sv
verilog/sid_voice.sv
bench/sid_voice_asserts.sv
bench/sid_voice_tb.sv

// ==== verilog/noise_lfsr.sv ====
`timescale 1ns/10ps

module noise_lfsr
  import sid_voice_pkg::*;
(
  input  logic    clock,
  input  logic    reset,
  input  phase_t  phase,
  input  logic    test,
  output sample_t noise
);

  lfsr_t   shift_reg;
  logic    tap_prev;
  logic    step;
  logic    feedback;
  sample_t sample;

  assign step = phase[NOISE_TAP_BIT] && !tap_prev;

  // Test bit forces ones into the feedback path
  assign feedback = (shift_reg[22] | test) ^ shift_reg[17];

  always_ff @(posedge clock)
  begin
    if (reset)
    begin
      tap_prev  <= 1'b0;
      shift_reg <= LFSR_SEED;
      sample    <= '0;
    end
    else
    begin
      tap_prev <= phase[NOISE_TAP_BIT];
      if (step)
      begin
        shift_reg <= {shift_reg[LFSR_W-2:0], feedback};
      end
      // Eight scattered taps, low nibble zero
      sample <= {shift_reg[21], shift_reg[19], shift_reg[15], shift_reg[12],
                 shift_reg[10], shift_reg[6], shift_reg[3], shift_reg[1],
                 4'b0000};
    end
  end

  assign noise = sample;

endmodule

// ==== verilog/output_stage.sv ====
`timescale 1ns/10ps

module output_stage
  import sid_voice_pkg::*;
(
  input  logic       clock,
  input  logic       reset,
  input  wave_sel_t  wave_select,
  input  sample_t    triangle,
  input  sample_t    sawtooth,
  input  sample_t    pulse,
  input  sample_t    noise,
  input  amplitude_t amplitude,
  output level_t     osc_out,
  output sample_t    signal_out
);

  sample_t              selected;
  logic [PRODUCT_W-1:0] product;

  // Only single waveforms are supported, mixes give silence
  always_comb
  begin
    case (wave_select)
      SEL_TRIANGLE:
      begin
        selected = triangle;
      end
      SEL_SAWTOOTH:
      begin
        selected = sawtooth;
      end
      SEL_PULSE:
      begin
        selected = pulse;
      end
      SEL_NOISE:
      begin
        selected = noise;
      end
      default:
      begin
        selected = '0;
      end
    endcase
  end

  assign osc_out = selected[SAMPLE_W-1 -: LEVEL_W];

  // Amplifier, one cycle behind the selector
  always_ff @(posedge clock)
  begin
    if (reset)
    begin
      product <= '0;
    end
    else
    begin
      product <= selected * amplitude;
    end
  end

  assign signal_out = product[PRODUCT_W-1 -: SAMPLE_W];

endmodule

// ==== verilog/phase_accumulator.sv ====
`timescale 1ns/10ps

module phase_accumulator
  import sid_voice_pkg::*;
(
  input  logic   clock,
  input  logic   reset,
  input  freq_t  frequency,
  input  logic   test,
  input  logic   sync_enable,
  input  logic   sync_source,
  output phase_t phase
);

  phase_t accumulator;
  logic   sync_source_prev;
  logic   sync_edge;
  logic   clear;

  // Neighbour MSB going from high to low
  assign sync_edge = sync_enable && !sync_source && sync_source_prev;

  assign clear = test || sync_edge;

  always_ff @(posedge clock)
  begin
    if (reset)
    begin
      sync_source_prev <= 1'b0;
    end
    else
    begin
      sync_source_prev <= sync_source;
    end
  end

  always_ff @(posedge clock)
  begin
    if (reset)
    begin
      accumulator <= '0;
    end
    else if (clear)
    begin
      accumulator <= '0;
    end
    else
    begin
      // Wraps modulo 2^24
      accumulator <= accumulator + phase_t'(frequency);
    end
  end

  assign phase = accumulator;

endmodule

// ==== verilog/sid_voice.sv ====
`timescale 1ns/10ps

module sid_voice
  import sid_voice_pkg::*;
(
  input  logic       clock,
  input  logic       reset,
  input  reg8_t      freq_lo,
  input  reg8_t      freq_hi,
  input  reg8_t      pw_lo,
  input  logic [3:0] pw_hi,
  input  reg8_t      control,
  input  amplitude_t amplitude,
  input  logic       osc_msb_in,
  output logic       osc_msb_out,
  output sample_t    signal_out,
  output level_t     osc_out
);

  freq_t        frequency;
  pulse_width_t pulse_width;
  wave_sel_t    wave_select;
  logic         test;
  logic         ring_enable;
  logic         sync_enable;

  phase_t  phase;
  sample_t noise;
  sample_t triangle;
  sample_t sawtooth;
  sample_t pulse;

  assign frequency   = {freq_hi, freq_lo};
  assign pulse_width = {pw_hi, pw_lo};

  // Gate bit 0 has no envelope to drive here
  assign test        = control[CTRL_TEST];
  assign ring_enable = control[CTRL_RING];
  assign sync_enable = control[CTRL_SYNC];
  assign wave_select = wave_sel_t'({control[CTRL_NOISE], control[CTRL_PULSE],
                                    control[CTRL_SAW], control[CTRL_TRI]});

  assign osc_msb_out = phase[PHASE_W-1];

  phase_accumulator oscillator (
    .clock       (clock),
    .reset       (reset),
    .frequency   (frequency),
    .test        (test),
    .sync_enable (sync_enable),
    .sync_source (osc_msb_in),
    .phase       (phase)
  );

  noise_lfsr noise_gen (
    .clock (clock),
    .reset (reset),
    .phase (phase),
    .test  (test),
    .noise (noise)
  );

  waveform_generator waves (
    .clock       (clock),
    .reset       (reset),
    .phase       (phase),
    .ring_enable (ring_enable),
    .ring_source (osc_msb_in),
    .pulse_width (pulse_width),
    .test        (test),
    .triangle    (triangle),
    .sawtooth    (sawtooth),
    .pulse       (pulse)
  );

  output_stage dca (
    .clock       (clock),
    .reset       (reset),
    .wave_select (wave_select),
    .triangle    (triangle),
    .sawtooth    (sawtooth),
    .pulse       (pulse),
    .noise       (noise),
    .amplitude   (amplitude),
    .osc_out     (osc_out),
    .signal_out  (signal_out)
  );

endmodule

// ==== verilog/sid_voice_pkg.sv ====
package sid_voice_pkg;

  // Architectural widths
  localparam int PHASE_W   = 24;
  localparam int FREQ_W    = 16;
  localparam int SAMPLE_W  = 12;
  localparam int LEVEL_W   = 8;
  localparam int AMP_W     = 8;
  localparam int REG_W     = 8;
  localparam int LFSR_W    = 23;
  localparam int PRODUCT_W = 20;

  typedef logic [PHASE_W-1:0]  phase_t;
  typedef logic [FREQ_W-1:0]   freq_t;
  typedef logic [SAMPLE_W-1:0] sample_t;
  typedef logic [SAMPLE_W-1:0] pulse_width_t;
  typedef logic [AMP_W-1:0]    amplitude_t;
  typedef logic [LEVEL_W-1:0]  level_t;
  typedef logic [REG_W-1:0]    reg8_t;
  typedef logic [LFSR_W-1:0]   lfsr_t;

  // Control register bit positions
  localparam int CTRL_NOISE = 7;
  localparam int CTRL_PULSE = 6;
  localparam int CTRL_SAW   = 5;
  localparam int CTRL_TRI   = 4;
  localparam int CTRL_TEST  = 3;
  localparam int CTRL_RING  = 2;
  localparam int CTRL_SYNC  = 1;

  // Accumulator bit that clocks the noise register
  localparam int NOISE_TAP_BIT = 19;

  // One-hot waveform codes from control bits 7..4
  typedef enum logic [3:0] {
    SEL_TRIANGLE = 4'b0001,
    SEL_SAWTOOTH = 4'b0010,
    SEL_PULSE    = 4'b0100,
    SEL_NOISE    = 4'b1000
  } wave_sel_t;

  // Noise register comes out of reset all ones
  localparam lfsr_t LFSR_SEED = '1;

endpackage

// ==== verilog/waveform_generator.sv ====
`timescale 1ns/10ps

module waveform_generator
  import sid_voice_pkg::*;
(
  input  logic         clock,
  input  logic         reset,
  input  phase_t       phase,
  input  logic         ring_enable,
  input  logic         ring_source,
  input  pulse_width_t pulse_width,
  input  logic         test,
  output sample_t      triangle,
  output sample_t      sawtooth,
  output sample_t      pulse
);

  sample_t saw_next;
  sample_t tri_next;
  sample_t pulse_next;
  logic    fold;

  sample_t tri_reg;
  sample_t saw_reg;
  sample_t pulse_reg;

  assign saw_next = phase[PHASE_W-1 -: SAMPLE_W];

  // Ring modulation flips the fold with the neighbour's MSB
  assign fold = phase[PHASE_W-1] ^ (ring_enable & ring_source);

  assign tri_next = {phase[PHASE_W-2 -: SAMPLE_W-1] ^ {(SAMPLE_W-1){fold}}, 1'b0};

  always_comb
  begin
    if (test || (saw_next >= pulse_width))
    begin
      pulse_next = '1;
    end
    else
    begin
      pulse_next = '0;
    end
  end

  always_ff @(posedge clock)
  begin
    if (reset)
    begin
      tri_reg   <= '0;
      saw_reg   <= '0;
      pulse_reg <= '0;
    end
    else
    begin
      tri_reg   <= tri_next;
      saw_reg   <= saw_next;
      pulse_reg <= pulse_next;
    end
  end

  assign triangle = tri_reg;
  assign sawtooth = saw_reg;
  assign pulse    = pulse_reg;

endmodule
